// ==== vlog.f ====
mario_pkg.sv
mario_fsm.sv
step_counter.sv
position_unit.sv
ladder_zone.sv
frame_select.sv
mario_top.sv
tb_mario.sv

// ==== Bender.yml ====
package:
  name: mario_move

sources:
  - mario_pkg.sv
  - mario_fsm.sv
  - step_counter.sv
  - position_unit.sv
  - ladder_zone.sv
  - frame_select.sv
  - mario_top.sv
  - target: test
    files:
      - tb_mario.sv

// ==== tb_mario.sv ====
`timescale 1ns/1ps

module tb_mario;
    import mario_pkg::*;

    logic           clk;
    logic           rst;
    logic           start;
    logic           over;
    logic           key_up;
    logic           key_down;
    logic           key_left;
    logic           key_right;
    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;
    mario_state_e   state;
    anim_frame_e    frame;

    // test table, one entry per row
    string          row_name [$];
    logic [6:0]     row_stim [$];    // rst, start, over, up, down, left, right
    int             row_cycles [$];
    logic [2:0]     row_state [$];
    logic [X_W-1:0] row_x [$];
    logic [Y_W-1:0] row_y [$];
    logic [3:0]     row_frame [$];
    bit             table_ready;
    int             pass_count;
    int             fail_count;

    mario_top u_mario_top (
        .clk(clk), .rst(rst), .start(start), .over(over),
        .key_up(key_up), .key_down(key_down), .key_left(key_left), .key_right(key_right),
        .x(x), .y(y), .state(state), .frame(frame)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    task automatic add_row(input string name, input logic [6:0] stim, input int cycles,
                           input logic [2:0] st, input logic [X_W-1:0] ex,
                           input logic [Y_W-1:0] ey, input logic [3:0] fr);
        row_name.push_back(name);
        row_stim.push_back(stim);
        row_cycles.push_back(cycles);
        row_state.push_back(st);
        row_x.push_back(ex);
        row_y.push_back(ey);
        row_frame.push_back(fr);
    endtask

    // expected values after the row's last clock
    task automatic load_table;
        add_row("reset_idle", 7'b0000000, 1, ST_INITIAL, 450, 425, FR_WALK_LEFT3);
        add_row("start", 7'b0100000, 2, ST_STANDING, 450, 425, FR_WALK_LEFT3);
        add_row("walk_right_clamp", 7'b0000001, 50, ST_WALKING, 606, 425, FR_WALK_RIGHT3);
        add_row("release_keys", 7'b0000000, 2, ST_STANDING, 606, 425, FR_WALK_RIGHT3);
        add_row("walk_left_start", 7'b0000010, 5, ST_WALKING, 590, 425, FR_WALK_LEFT1);
        add_row("walk_left_to_ladder", 7'b0000010, 132, ST_WALKING, 62, 425, FR_WALK_LEFT3);
        add_row("climb_up", 7'b0001000, 10, ST_CLIMBING, 62, 398, FR_CLIMB2);
        // last climb step lands at 335, one step past the box top
        add_row("climb_off_top", 7'b0001000, 22, ST_STANDING, 62, 335, FR_WALK_LEFT3);
        add_row("game_over", 7'b0010000, 2, ST_DYING, 62, 335, FR_DIE1);
        add_row("dying_holds", 7'b0000000, 10, ST_DYING, 62, 335, FR_DIE2);
        add_row("dying_frame3", 7'b0000000, 8, ST_DYING, 62, 335, FR_DIE3);
        add_row("dying_frame4", 7'b0000000, 8, ST_DYING, 62, 335, FR_DIE4);
        add_row("reset_again", 7'b1000000, 3, ST_INITIAL, 450, 425, FR_WALK_LEFT3);
        add_row("restart", 7'b0100000, 2, ST_STANDING, 450, 425, FR_WALK_LEFT3);
    endtask

    task automatic drive_row(input int i);
        {rst, start, over, key_up, key_down, key_left, key_right} <= row_stim[i];
    endtask

    task automatic check_row(input int i);
        if (state !== row_state[i] || x !== row_x[i] || y !== row_y[i] ||
            frame !== row_frame[i]) begin
            $display("** Error %s: expected state %0d x %0d y %0d frame %0d",
                     row_name[i], row_state[i], row_x[i], row_y[i], row_frame[i],
                     ", actual state %0d x %0d y %0d frame %0d", state, x, y, frame);
            fail_count++;
        end else begin
            $display("pass  %s", row_name[i]);
            pass_count++;
        end
    endtask

    initial begin
        int i;
        rst         = 1'b1;
        start       = 1'b0;
        over        = 1'b0;
        key_up      = 1'b0;
        key_down    = 1'b0;
        key_left    = 1'b0;
        key_right   = 1'b0;
        pass_count  = 0;
        fail_count  = 0;
        load_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        drive_row(0);  // drops rst as well
        for (i = 0; i < row_name.size(); i++) begin
            repeat (row_cycles[i]) @(posedge clk);
            // outputs are all flops, so the next row may start on this edge
            if (i + 1 < row_name.size())
                drive_row(i + 1);
            @(negedge clk);
            check_row(i);
        end
        $display("%0d tests run, %0d passed, %0d failed",
                 row_name.size(), pass_count, fail_count);
        if (fail_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // watchdog, sized from the table
    initial begin
        int total;
        wait (table_ready);
        total = 0;
        foreach (row_cycles[k])
            total += row_cycles[k];
        #((total + 20) * 40);
        $display("timeout: the run did not finish within %0d clock cycles", total + 20);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== mario_top.sv ====
`timescale 1ns/1ps

module mario_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      over,
    input  logic                      key_up,
    input  logic                      key_down,
    input  logic                      key_left,
    input  logic                      key_right,
    output logic [mario_pkg::X_W-1:0] x,
    output logic [mario_pkg::Y_W-1:0] y,
    output mario_pkg::mario_state_e   state,
    output mario_pkg::anim_frame_e    frame
);
    import mario_pkg::*;

    logic               in_ladder;
    logic               at_left;
    logic               at_right;
    logic               facing_left;
    logic [COUNT_W-1:0] count;  // animation step

    mario_fsm u_fsm (
        .clk(clk), .rst(rst), .start(start), .over(over),
        .key_up(key_up), .key_down(key_down), .key_left(key_left), .key_right(key_right),
        .in_ladder(in_ladder), .at_left(at_left), .at_right(at_right),
        .state(state)
    );

    step_counter u_counter (
        .clk(clk), .rst(rst), .state(state),
        .key_up(key_up), .key_down(key_down), .count(count)
    );

    position_unit u_position (
        .clk(clk), .rst(rst), .state(state),
        .key_up(key_up), .key_down(key_down), .key_left(key_left), .key_right(key_right),
        .x(x), .y(y), .facing_left(facing_left), .at_left(at_left), .at_right(at_right)
    );

    ladder_zone u_ladder (.x(x), .y(y), .in_ladder(in_ladder));

    frame_select u_frame (
        .clk(clk), .rst(rst), .state(state), .facing_left(facing_left), .count(count),
        .key_up(key_up), .key_down(key_down), .frame(frame)
    );

endmodule

// ==== frame_select.sv ====
`timescale 1ns/1ps

module frame_select (
    input  logic                          clk,
    input  logic                          rst,
    input  mario_pkg::mario_state_e       state,
    input  logic                          facing_left,
    input  logic [mario_pkg::COUNT_W-1:0] count,
    input  logic                          key_up,
    input  logic                          key_down,
    output mario_pkg::anim_frame_e        frame
);
    import mario_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame <= FR_WALK_LEFT3;  // standing, facing left
        end else begin
            case (state)
                ST_WALKING: begin
                    // 4-clock phases, frame 3 between the two strides
                    case (count[3:2])
                        2'd0: frame <= facing_left ? FR_WALK_LEFT1 : FR_WALK_RIGHT1;
                        2'd2: frame <= facing_left ? FR_WALK_LEFT2 : FR_WALK_RIGHT2;
                        default: frame <= facing_left ? FR_WALK_LEFT3 : FR_WALK_RIGHT3;
                    endcase
                end
                ST_DYING: begin
                    case (count[4:3])  // 8 clocks per frame
                        2'd0: frame <= FR_DIE1;
                        2'd1: frame <= FR_DIE2;
                        2'd2: frame <= FR_DIE3;
                        default: frame <= FR_DIE4;
                    endcase
                end
                ST_CLIMBING: begin
                    if ((key_up || key_down) && count[2])
                        frame <= FR_CLIMB2;
                    else
                        frame <= FR_CLIMB1;  // idle on the ladder too
                end
                default: frame <= facing_left ? FR_WALK_LEFT3 : FR_WALK_RIGHT3;
            endcase
        end
    end

    a_die_frame: assert property (
        @(posedge clk) disable iff (rst)
        state == ST_DYING |=> frame inside {FR_DIE1, FR_DIE2, FR_DIE3, FR_DIE4}
    ) else $error("dying without a death frame, frame %0d", frame);

endmodule

// ==== ladder_zone.sv ====
`timescale 1ns/1ps

module ladder_zone (
    input  logic [mario_pkg::X_W-1:0] x,
    input  logic [mario_pkg::Y_W-1:0] y,
    output logic                      in_ladder
);
    import mario_pkg::*;

    logic [NUM_LADDERS-1:0] hit;  // one bit per ladder box

    always_comb begin
        for (int i = 0; i < NUM_LADDERS; i++) begin
            // x inclusive, y strictly inside
            hit[i] = (x >= LADDER_LX[i]) && (x <= LADDER_RX[i]) &&
                     (y > LADDER_TY[i]) && (y < LADDER_BY[i]);
        end
    end

    assign in_ladder = |hit;

endmodule

// ==== position_unit.sv ====
`timescale 1ns/1ps

module position_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  mario_pkg::mario_state_e   state,
    input  logic                      key_up,
    input  logic                      key_down,
    input  logic                      key_left,
    input  logic                      key_right,
    output logic [mario_pkg::X_W-1:0] x,
    output logic [mario_pkg::Y_W-1:0] y,
    output logic                      facing_left,
    output logic                      at_left,
    output logic                      at_right
);
    import mario_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            x           <= START_X;
            y           <= START_Y;
            facing_left <= 1'b1;
        end else begin
            case (state)
                ST_INITIAL: begin
                    x <= START_X;
                    y <= START_Y;
                end
                ST_WALKING: begin
                    if (key_left) begin  // left wins over right
                        facing_left <= 1'b1;
                        if (x < LEFT_BORDER + WALK_STEP)
                            x <= LEFT_BORDER;
                        else
                            x <= x - WALK_STEP;
                    end else if (key_right) begin
                        facing_left <= 1'b0;
                        if (x + WALK_STEP > X_MAX)
                            x <= X_MAX;
                        else
                            x <= x + WALK_STEP;
                    end
                end
                ST_CLIMBING: begin
                    if (key_up) begin
                        if (y < TOP_BORDER + CLIMB_STEP)
                            y <= TOP_BORDER;
                        else
                            y <= y - CLIMB_STEP;
                    end else if (key_down) begin
                        if (y + CLIMB_STEP > Y_MAX)
                            y <= Y_MAX;
                        else
                            y <= y + CLIMB_STEP;
                    end
                end
                default: ;  // standing and dying hold position
            endcase
        end
    end

    assign at_left  = (x <= LEFT_BORDER);
    assign at_right = (x >= X_MAX);

    a_on_screen: assert property (
        @(posedge clk) disable iff (rst)
        x >= LEFT_BORDER && x <= X_MAX && y >= TOP_BORDER && y <= Y_MAX
    ) else $error("sprite left the screen at (%0d,%0d)", x, y);

endmodule

// ==== step_counter.sv ====
`timescale 1ns/1ps

module step_counter (
    input  logic                          clk,
    input  logic                          rst,
    input  mario_pkg::mario_state_e       state,
    input  logic                          key_up,
    input  logic                          key_down,
    output logic [mario_pkg::COUNT_W-1:0] count
);
    import mario_pkg::*;

    mario_state_e prev_state;  // for spotting a state change

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_state <= ST_INITIAL;
            count      <= '0;
        end else begin
            prev_state <= state;
            if (state != prev_state)
                count <= '0;  // first clock of a new state
            else if (state == ST_WALKING || state == ST_DYING ||
                     (state == ST_CLIMBING && (key_up || key_down)))
                count <= count + 1'b1;  // wraps at 32
        end
    end

endmodule

// ==== mario_fsm.sv ====
`timescale 1ns/1ps

module mario_fsm (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   over,
    input  logic                   key_up,
    input  logic                   key_down,
    input  logic                   key_left,
    input  logic                   key_right,
    input  logic                   in_ladder,
    input  logic                   at_left,
    input  logic                   at_right,
    output mario_pkg::mario_state_e state
);
    import mario_pkg::*;

    mario_state_e next_state;
    logic         climb_req;
    logic         side_exit;

    assign climb_req = (key_up || key_down) && in_ladder;
    // stepping off the ladder sideways, only if not against that border
    assign side_exit = (key_left && !at_left) || (key_right && !at_right);

    always_ff @(posedge clk) begin
        if (rst)
            state <= ST_INITIAL;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_INITIAL: begin
                if (start) next_state = ST_STANDING;
            end
            ST_STANDING: begin
                if (over)                       next_state = ST_DYING;
                else if (climb_req)             next_state = ST_CLIMBING;
                else if (key_left || key_right) next_state = ST_WALKING;
            end
            ST_WALKING: begin
                if (over)                          next_state = ST_DYING;
                else if (climb_req)                next_state = ST_CLIMBING;
                else if (!key_left && !key_right)  next_state = ST_STANDING;
            end
            ST_CLIMBING: begin
                if (over)            next_state = ST_DYING;
                else if (side_exit)  next_state = ST_WALKING;
                else if (!in_ladder) next_state = ST_STANDING;  // ran off the box
            end
            ST_DYING: next_state = ST_DYING;  // only rst gets out
            default:  next_state = ST_INITIAL;
        endcase
    end

    a_state_legal: assert property (
        @(posedge clk) disable iff (rst)
        state inside {ST_INITIAL, ST_WALKING, ST_STANDING, ST_DYING, ST_CLIMBING}
    ) else $error("state register holds an unnamed code %0d", state);

endmodule

// ==== mario_pkg.sv ====
package mario_pkg;

    // movement states, codes 1 and 2 (jump, fly) left free
    typedef enum logic [2:0] {
        ST_INITIAL  = 3'd0,
        ST_WALKING  = 3'd3,
        ST_STANDING = 3'd4,
        ST_DYING    = 3'd5,
        ST_CLIMBING = 3'd6
    } mario_state_e;

    // sprite frame codes as the renderer expects them
    typedef enum logic [3:0] {
        FR_STAND       = 4'd0,
        FR_WALK_LEFT1  = 4'd1,
        FR_WALK_LEFT2  = 4'd2,
        FR_WALK_LEFT3  = 4'd3,
        FR_WALK_RIGHT1 = 4'd4,
        FR_WALK_RIGHT2 = 4'd5,
        FR_WALK_RIGHT3 = 4'd14,
        FR_CLIMB1      = 4'd8,
        FR_CLIMB2      = 4'd9,
        FR_DIE1        = 4'd10,
        FR_DIE2        = 4'd11,
        FR_DIE3        = 4'd12,
        FR_DIE4        = 4'd13
    } anim_frame_e;

    localparam int X_W     = 10;
    localparam int Y_W     = 9;
    localparam int COUNT_W = 5;

    // screen borders in pixels
    localparam logic [Y_W-1:0] TOP_BORDER    = 9'd5;
    localparam logic [Y_W-1:0] BOTTOM_BORDER = 9'd461;
    localparam logic [X_W-1:0] LEFT_BORDER   = 10'd5;
    localparam logic [X_W-1:0] RIGHT_BORDER  = 10'd640;

    localparam logic [X_W-1:0] SPRITE_W = 10'd34;
    localparam logic [Y_W-1:0] SPRITE_H = 9'd36;

    // furthest top-left corner that keeps the sprite on screen
    localparam logic [X_W-1:0] X_MAX = RIGHT_BORDER - SPRITE_W;   // 606
    localparam logic [Y_W-1:0] Y_MAX = BOTTOM_BORDER - SPRITE_H;  // 425

    localparam logic [X_W-1:0] START_X = 10'd450;
    localparam logic [Y_W-1:0] START_Y = 9'd425;

    localparam logic [X_W-1:0] WALK_STEP  = 10'd4;  // pixels per clock
    localparam logic [Y_W-1:0] CLIMB_STEP = 9'd3;

    // ladder boxes, entry i across the four tables
    localparam int NUM_LADDERS = 5;
    localparam logic [X_W-1:0] LADDER_LX [NUM_LADDERS] =
        '{10'd339, 10'd541, 10'd48, 10'd546, 10'd53};
    localparam logic [X_W-1:0] LADDER_RX [NUM_LADDERS] =
        '{10'd353, 10'd555, 10'd62, 10'd560, 10'd67};
    localparam logic [Y_W-1:0] LADDER_TY [NUM_LADDERS] =
        '{9'd15, 9'd77, 9'd159, 9'd248, 9'd338};
    localparam logic [Y_W-1:0] LADDER_BY [NUM_LADDERS] =
        '{9'd81, 9'd163, 9'd252, 9'd342, 9'd427};

endpackage
